/* rv_id_stage.f */
+incdir+verilog
verilog/rv_id_pkg.sv
verilog/rv_id_latch.sv
verilog/rv_inst_decode.sv
verilog/rv_gpr_file.sv
verilog/rv_operand_bypass.sv
verilog/rv_branch_unit.sv
verilog/rv_id_stage.sv
test/tb_rv_id_stage.sv

/* Bender.yml */
package:
  name: rv_id_stage

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/rv_id_pkg.sv
      - verilog/rv_id_latch.sv
      - verilog/rv_inst_decode.sv
      - verilog/rv_gpr_file.sv
      - verilog/rv_operand_bypass.sv
      - verilog/rv_branch_unit.sv
      - verilog/rv_id_stage.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - test/tb_rv_id_stage.sv

/* test/tb_rv_id_stage.sv */
// directed testbench for the decode stage, compiled from the file list with tb_rv_id_stage as top
`timescale 1ns/1ns
`include "rv_id_macros.svh"

module tb_rv_id_stage;
  import rv_id_pkg::*;

  logic      i_clk, i_arst_n, i_fs_to_ds_valid, i_es_allowin, i_ws_wen, i_es_load;
  inst_t     i_fs_inst;
  xlen_t     i_fs_pc, i_ws_wdata, i_es_result, i_ms_result, i_ws_result;
  reg_addr_t i_ws_waddr, i_es_rd, i_ms_rd, i_ws_rd;
  logic      o_ds_allowin, o_ds_to_es_valid, o_alu_src1_pc, o_alu_src2_imm, o_word_sel;
  logic      o_gpr_wen, o_mem_ren, o_mem_wen, o_invalid, o_br_taken, o_br_stall;
  xlen_t     o_rs1_data, o_rs2_data, o_imm, o_pc, o_br_target;
  reg_addr_t o_rd;
  alu_op_t   o_alu_op;
  mem_op_t   o_mem_op;

  integer seed;
  int     errs, errs_at_start, tests_ok, tests_bad, cycles;
  string  cur_test;
  xlen_t  x5_val, x6_val;  // what the testbench last wrote to x5 and x6

  rv_id_stage uut (.*);

  always #50 i_clk = ~i_clk;

  // about 50 cycles of tests, generous margin
  always @(posedge i_clk) begin
    cycles++;
    if (cycles >= 400) begin
      $display("timeout, no end of tests after %0d cycles", cycles);
      $display("Simulation failed");
      $finish;
    end
  end

  function automatic inst_t enc_i(input logic [6:0] opc, input reg_addr_t rd,
                                  input logic [2:0] f3, input reg_addr_t rs1,
                                  input logic [11:0] imm);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic inst_t enc_r(input logic [6:0] f7, input reg_addr_t rs2,
                                  input reg_addr_t rs1, input logic [2:0] f3,
                                  input reg_addr_t rd, input logic [6:0] opc);
    return {f7, rs2, rs1, f3, rd, opc};
  endfunction

  function automatic inst_t enc_b(input logic [2:0] f3, input reg_addr_t rs1,
                                  input reg_addr_t rs2, input logic [12:0] imm);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], `RV_OPC_BRANCH};
  endfunction

  function automatic inst_t enc_j(input reg_addr_t rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, `RV_OPC_JAL};
  endfunction

  // taken rule per branch funct3
  function automatic logic branch_expect(input logic [2:0] f, input xlen_t x, input xlen_t y);
    case (f)
      `RV_F3_BEQ:  return x == y;
      `RV_F3_BNE:  return x != y;
      `RV_F3_BLT:  return $signed(x) < $signed(y);
      `RV_F3_BGEU: return x >= y;
      default:     return 1'b0;
    endcase
  endfunction

  task automatic step();
    @(posedge i_clk);
    #10;
  endtask

  task automatic check(input string what, input xlen_t exp, input xlen_t act);
    if (exp !== act) begin
      $display("Fail %s %s: expected %h, actual %h", cur_test, what, exp, act);
      errs++;
    end
  endtask

  task automatic start(input string name);
    cur_test = name;
    errs_at_start = errs;
  endtask

  // lets the last instruction drain, then prints the test line
  task automatic report();
    step();
    if (errs == errs_at_start) begin
      $display("%s: ok", cur_test);
      tests_ok++;
    end else begin
      $display("%s: %0d errors", cur_test, errs - errs_at_start);
      tests_bad++;
    end
  endtask

  task automatic write_reg(input reg_addr_t addr, input xlen_t data);
    i_ws_wen = 1'b1;
    i_ws_waddr = addr;
    i_ws_wdata = data;
    step();
    i_ws_wen = 1'b0;
  endtask

  // offer one instruction and wait for the accepting edge
  task automatic issue(input inst_t inst, input xlen_t pc);
    i_fs_to_ds_valid = 1'b1;
    i_fs_inst = inst;
    i_fs_pc = pc;
    while (!o_ds_allowin) begin
      step();
    end
    step();
    i_fs_to_ds_valid = 1'b0;
  endtask

  task automatic reset_test();
    start("reset");
    check("allowin", 1, o_ds_allowin);
    check("to_es_valid", 0, o_ds_to_es_valid);
    check("br_taken", 0, o_br_taken);
    check("br_stall", 0, o_br_stall);
    report();
  endtask

  task automatic decode_test();
    start("decode");
    x5_val = {$random(seed), $random(seed)};
    x6_val = {$random(seed), $random(seed)};
    write_reg(5'd5, x5_val);
    write_reg(5'd6, x6_val);
    issue(enc_i(`RV_OPC_OP_IMM, 5'd7, 3'b000, 5'd5, 12'hffd), 64'h1000);  // addi x7, x5, -3
    check("addi valid", 1, o_ds_to_es_valid);
    check("addi rs1", x5_val, o_rs1_data);
    check("addi imm", 64'hffff_ffff_ffff_fffd, o_imm);
    check("addi alu_op", `RV_ALU_ADD, o_alu_op);
    check("addi rd", 7, o_rd);
    check("addi gpr_wen", 1, o_gpr_wen);
    check("addi src2_imm", 1, o_alu_src2_imm);
    check("addi src1_pc", 0, o_alu_src1_pc);
    check("addi word_sel", 0, o_word_sel);
    issue(enc_r(7'h20, 5'd6, 5'd5, 3'b000, 5'd8, `RV_OPC_OP), 64'h1004);  // sub x8, x5, x6
    check("sub valid", 1, o_ds_to_es_valid);
    check("sub rs1", x5_val, o_rs1_data);
    check("sub rs2", x6_val, o_rs2_data);
    check("sub alu_op", `RV_ALU_SUB, o_alu_op);
    check("sub rd", 8, o_rd);
    check("sub src2_imm", 0, o_alu_src2_imm);
    issue(enc_i(`RV_OPC_OP_IMM_32, 5'd9, 3'b000, 5'd0, 12'd5), 64'h1008);  // addiw x9, x0, 5
    check("x0 read", 0, o_rs1_data);
    check("addiw word_sel", 1, o_word_sel);
    issue(enc_i(`RV_OPC_LOAD, 5'd14, 3'b011, 5'd5, 12'd8), 64'h100c);  // ld x14, 8(x5)
    check("ld mem_ren", 1, o_mem_ren);
    check("ld mem_wen", 0, o_mem_wen);
    check("ld mem_op", 3'b011, o_mem_op);
    check("ld gpr_wen", 1, o_gpr_wen);
    issue(enc_r(7'h00, 5'd6, 5'd5, 3'b011, 5'd16, `RV_OPC_STORE), 64'h1010);  // sd x6, 16(x5)
    check("sd mem_wen", 1, o_mem_wen);
    check("sd mem_ren", 0, o_mem_ren);
    check("sd imm", 16, o_imm);
    check("sd rs2", x6_val, o_rs2_data);
    check("sd gpr_wen", 0, o_gpr_wen);
    report();
  endtask

  task automatic forward_test();
    xlen_t r_es;
    xlen_t r_ms;
    start("forward");
    r_es = {$random(seed), $random(seed)};
    r_ms = {$random(seed), $random(seed)};
    i_es_allowin = 1'b0;  // keep add x10, x5, x0 in the stage
    issue(enc_r(7'h00, 5'd0, 5'd5, 3'b000, 5'd10, `RV_OPC_OP), 64'h2000);
    {i_es_rd, i_ms_rd, i_ws_rd} = {5'd5, 5'd5, 5'd5};
    {i_es_result, i_ms_result} = {r_es, r_ms};
    i_ws_result = {$random(seed), $random(seed)};
    step();
    check("es first", r_es, o_rs1_data);
    i_es_rd = 5'd0;
    step();
    check("ms before ws", r_ms, o_rs1_data);
    {i_ms_rd, i_ws_rd} = '0;
    step();
    check("rd x0 ignored", 0, o_rs2_data);
    check("register file", x5_val, o_rs1_data);
    i_es_allowin = 1'b1;
    report();
  endtask

  task automatic load_use_test();
    xlen_t r_es;
    start("load_use");
    r_es = {$random(seed), $random(seed)};
    i_es_result = r_es;
    i_es_load = 1'b1;
    i_es_rd = 5'd6;
    issue(enc_r(7'h00, 5'd6, 5'd5, 3'b000, 5'd11, `RV_OPC_OP), 64'h3000);
    check("stall valid", 0, o_ds_to_es_valid);
    check("stall allowin", 0, o_ds_allowin);
    step();
    check("held valid", 0, o_ds_to_es_valid);
    check("held pc", 64'h3000, o_pc);
    i_es_load = 1'b0;
    #1;
    check("released valid", 1, o_ds_to_es_valid);
    check("forwarded rs2", r_es, o_rs2_data);
    step();
    check("left stage", 0, o_ds_to_es_valid);
    i_es_load = 1'b1;
    i_es_rd = 5'd5;
    issue(enc_b(`RV_F3_BEQ, 5'd5, 5'd5, 13'd16), 64'h3100);
    check("beq taken", 1, o_br_taken);
    check("beq br_stall", 1, o_br_stall);
    check("beq target", 64'h3110, o_br_target);
    i_es_load = 1'b0;
    i_es_rd = 5'd0;
    report();
  endtask

  task automatic backpressure_test();
    start("backpressure");
    i_es_allowin = 1'b0;
    issue(enc_i(`RV_OPC_OP_IMM, 5'd12, 3'b000, 5'd5, 12'd1), 64'h4000);
    i_fs_to_ds_valid = 1'b1;  // second one waits at the fetch boundary
    i_fs_inst = enc_i(`RV_OPC_OP_IMM, 5'd13, 3'b000, 5'd5, 12'd2);
    i_fs_pc = 64'h4004;
    repeat (3) begin
      check("held pc", 64'h4000, o_pc);
      check("held rd", 12, o_rd);
      check("allowin low", 0, o_ds_allowin);
      step();
    end
    i_es_allowin = 1'b1;
    step();
    i_fs_to_ds_valid = 1'b0;
    check("second pc", 64'h4004, o_pc);
    check("second rd", 13, o_rd);
    check("second imm", 2, o_imm);
    report();
  endtask

  task automatic branch_test();
    logic [14:0] funcs;
    logic [2:0]  f;
    xlen_t       y;
    xlen_t       pc;
    start("branch");
    funcs = {`RV_F3_BEQ, `RV_F3_BGEU, `RV_F3_BLT, `RV_F3_BNE, `RV_F3_BEQ};
    x5_val = {$random(seed), $random(seed)};
    x6_val = {$random(seed), $random(seed)};
    write_reg(5'd5, x5_val);
    write_reg(5'd6, x6_val);
    for (int k = 0; k < 5; k++) begin
      f = funcs[3*k +: 3];
      y = (k == 4) ? x5_val : x6_val;  // last one compares x5 with itself
      pc = {$random(seed), $random(seed)};
      pc[1:0] = 2'b00;
      issue(enc_b(f, 5'd5, (k == 4) ? 5'd5 : 5'd6, 13'h1fe8), pc);
      check("branch taken", branch_expect(f, x5_val, y), o_br_taken);
      check("branch target", pc - 64'd24, o_br_target);
    end
    issue(enc_j(5'd1, 21'h1ff000), 64'h5000);
    check("jal taken", 1, o_br_taken);
    check("jal target", 64'h4000, o_br_target);
    check("jal rd", 1, o_rd);
    check("jal src1_pc", 1, o_alu_src1_pc);
    check("jal br_stall", 0, o_br_stall);
    issue(enc_i(`RV_OPC_JALR, 5'd1, 3'b000, 5'd5, 12'hff9), 64'h5004);
    check("jalr taken", 1, o_br_taken);
    check("jalr target", (x5_val - 64'd7) & ~64'd1, o_br_target);
    issue(32'h0000_007f, 64'h5008);
    check("invalid flag", 1, o_invalid);
    check("invalid gpr_wen", 0, o_gpr_wen);
    report();
  endtask

  initial begin
    seed = 32'ha23e;
    i_clk = 1'b0;
    i_arst_n = 1'b0;
    i_es_allowin = 1'b1;
    {i_fs_to_ds_valid, i_ws_wen, i_es_load} = '0;
    {i_fs_inst, i_fs_pc, i_ws_wdata} = '0;
    {i_ws_waddr, i_es_rd, i_ms_rd, i_ws_rd} = '0;
    {i_es_result, i_ms_result, i_ws_result} = '0;
    repeat (4) @(posedge i_clk);
    #10;
    i_arst_n = 1'b1;
    reset_test();
    decode_test();
    forward_test();
    load_use_test();
    backpressure_test();
    branch_test();
    $display("tests ok %0d, tests failed %0d, failed checks %0d", tests_ok, tests_bad, errs);
    if (errs == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

/* verilog/rv_id_stage.sv */
// RV64I decode stage top level, sits between fetch and execute in the five-stage pipeline
`timescale 1ns/1ns

module rv_id_stage (
  input  logic                 i_clk,
  input  logic                 i_arst_n,
  // fetch side
  input  logic                 i_fs_to_ds_valid,
  input  rv_id_pkg::inst_t     i_fs_inst,
  input  rv_id_pkg::xlen_t     i_fs_pc,
  output logic                 o_ds_allowin,
  // execute side
  input  logic                 i_es_allowin,
  output logic                 o_ds_to_es_valid,
  output rv_id_pkg::xlen_t     o_rs1_data,
  output rv_id_pkg::xlen_t     o_rs2_data,
  output rv_id_pkg::xlen_t     o_imm,
  output rv_id_pkg::xlen_t     o_pc,
  output rv_id_pkg::reg_addr_t o_rd,
  output rv_id_pkg::alu_op_t   o_alu_op,
  output logic                 o_alu_src1_pc,
  output logic                 o_alu_src2_imm,
  output logic                 o_word_sel,
  output logic                 o_gpr_wen,
  output logic                 o_mem_ren,
  output logic                 o_mem_wen,
  output rv_id_pkg::mem_op_t   o_mem_op,
  output logic                 o_invalid,
  // branch back to fetch
  output logic                 o_br_taken,
  output rv_id_pkg::xlen_t     o_br_target,
  output logic                 o_br_stall,
  // write-back port
  input  logic                 i_ws_wen,
  input  rv_id_pkg::reg_addr_t i_ws_waddr,
  input  rv_id_pkg::xlen_t     i_ws_wdata,
  // forwarding
  input  rv_id_pkg::reg_addr_t i_es_rd,
  input  rv_id_pkg::xlen_t     i_es_result,
  input  logic                 i_es_load,
  input  rv_id_pkg::reg_addr_t i_ms_rd,
  input  rv_id_pkg::xlen_t     i_ms_result,
  input  rv_id_pkg::reg_addr_t i_ws_rd,
  input  rv_id_pkg::xlen_t     i_ws_result
);
  import rv_id_pkg::*;

  logic      ds_valid;
  inst_t     ds_inst;
  reg_addr_t rs1;
  reg_addr_t rs2;
  xlen_t     rf_rs1;  // raw register file reads
  xlen_t     rf_rs2;
  logic      load_stall;
  logic      bren;
  logic      jal;
  logic      jalr;
  logic [2:0] br_func;

  rv_id_latch u_latch (
    .i_clk            (i_clk),
    .i_arst_n         (i_arst_n),
    .i_fs_to_ds_valid (i_fs_to_ds_valid),
    .i_fs_inst        (i_fs_inst),
    .i_fs_pc          (i_fs_pc),
    .i_es_allowin     (i_es_allowin),
    .i_load_stall     (load_stall),
    .o_ds_allowin     (o_ds_allowin),
    .o_ds_valid       (ds_valid),
    .o_ds_to_es_valid (o_ds_to_es_valid),
    .o_inst           (ds_inst),
    .o_pc             (o_pc)
  );

  rv_inst_decode u_decode (
    .i_inst         (ds_inst),
    .o_rs1          (rs1),
    .o_rs2          (rs2),
    .o_rd           (o_rd),
    .o_imm          (o_imm),
    .o_alu_op       (o_alu_op),
    .o_alu_src1_pc  (o_alu_src1_pc),
    .o_alu_src2_imm (o_alu_src2_imm),
    .o_word_sel     (o_word_sel),
    .o_gpr_wen      (o_gpr_wen),
    .o_mem_ren      (o_mem_ren),
    .o_mem_wen      (o_mem_wen),
    .o_load         (),            // execute reports its own load via i_es_load
    .o_bren         (bren),
    .o_jal          (jal),
    .o_jalr         (jalr),
    .o_mem_op       (o_mem_op),
    .o_br_func      (br_func),
    .o_invalid      (o_invalid)
  );

  rv_gpr_file u_gpr (
    .i_clk    (i_clk),
    .i_arst_n (i_arst_n),
    .i_raddr1 (rs1),
    .i_raddr2 (rs2),
    .i_wen    (i_ws_wen),
    .i_waddr  (i_ws_waddr),
    .i_wdata  (i_ws_wdata),
    .o_rdata1 (rf_rs1),
    .o_rdata2 (rf_rs2)
  );

  rv_operand_bypass u_bypass (
    .i_rs1        (rs1),
    .i_rs2        (rs2),
    .i_rf_rs1     (rf_rs1),
    .i_rf_rs2     (rf_rs2),
    .i_es_rd      (i_es_rd),
    .i_es_result  (i_es_result),
    .i_es_load    (i_es_load),
    .i_ms_rd      (i_ms_rd),
    .i_ms_result  (i_ms_result),
    .i_ws_rd      (i_ws_rd),
    .i_ws_result  (i_ws_result),
    .o_rs1_data   (o_rs1_data),
    .o_rs2_data   (o_rs2_data),
    .o_load_stall (load_stall)
  );

  rv_branch_unit u_branch (
    .i_ds_valid   (ds_valid),
    .i_bren       (bren),
    .i_jal        (jal),
    .i_jalr       (jalr),
    .i_br_func    (br_func),
    .i_rs1_data   (o_rs1_data),
    .i_rs2_data   (o_rs2_data),
    .i_pc         (o_pc),
    .i_imm        (o_imm),
    .i_load_stall (load_stall),
    .o_br_taken   (o_br_taken),
    .o_br_target  (o_br_target),
    .o_br_stall   (o_br_stall)
  );

endmodule

/* verilog/rv_branch_unit.sv */
// branch and jump resolution in decode, drives the redirect target back to fetch
`timescale 1ns/1ns
`include "rv_id_macros.svh"

module rv_branch_unit (
  input  logic             i_ds_valid,
  input  logic             i_bren,
  input  logic             i_jal,
  input  logic             i_jalr,
  input  logic [2:0]       i_br_func,
  input  rv_id_pkg::xlen_t i_rs1_data,
  input  rv_id_pkg::xlen_t i_rs2_data,
  input  rv_id_pkg::xlen_t i_pc,
  input  rv_id_pkg::xlen_t i_imm,
  input  logic             i_load_stall,
  output logic             o_br_taken,
  output rv_id_pkg::xlen_t o_br_target,
  output logic             o_br_stall
);
  import rv_id_pkg::*;

  logic  cond;
  logic  lt_s;
  logic  lt_u;
  xlen_t jalr_sum;

  assign lt_s = $signed(i_rs1_data) < $signed(i_rs2_data);
  assign lt_u = i_rs1_data < i_rs2_data;

  always_comb begin
    case (i_br_func)
      `RV_F3_BEQ:  cond = (i_rs1_data == i_rs2_data);
      `RV_F3_BNE:  cond = (i_rs1_data != i_rs2_data);
      `RV_F3_BLT:  cond = lt_s;
      `RV_F3_BGE:  cond = ~lt_s;
      `RV_F3_BLTU: cond = lt_u;
      `RV_F3_BGEU: cond = ~lt_u;
      default:     cond = 1'b0;
    endcase
  end

  assign jalr_sum    = i_rs1_data + i_imm;
  assign o_br_target = i_jalr ? {jalr_sum[63:1], 1'b0} : i_pc + i_imm;
  assign o_br_taken  = i_ds_valid & (i_jal | i_jalr | (i_bren & cond));
  // operands may still change, fetch must not trust the target yet
  assign o_br_stall  = o_br_taken & i_load_stall;

endmodule

/* verilog/rv_operand_bypass.sv */
// operand forwarding from execute, memory and write-back, plus load-use hazard detect
`timescale 1ns/1ns

module rv_operand_bypass (
  input  rv_id_pkg::reg_addr_t i_rs1,
  input  rv_id_pkg::reg_addr_t i_rs2,
  input  rv_id_pkg::xlen_t     i_rf_rs1,
  input  rv_id_pkg::xlen_t     i_rf_rs2,
  input  rv_id_pkg::reg_addr_t i_es_rd,
  input  rv_id_pkg::xlen_t     i_es_result,
  input  logic                 i_es_load,
  input  rv_id_pkg::reg_addr_t i_ms_rd,
  input  rv_id_pkg::xlen_t     i_ms_result,
  input  rv_id_pkg::reg_addr_t i_ws_rd,
  input  rv_id_pkg::xlen_t     i_ws_result,
  output rv_id_pkg::xlen_t     o_rs1_data,
  output rv_id_pkg::xlen_t     o_rs2_data,
  output logic                 o_load_stall
);
  import rv_id_pkg::*;

  // x0 results are never forwarded
  function automatic logic hit(input reg_addr_t rd, input reg_addr_t src);
    return (rd != '0) && (rd == src);
  endfunction

  logic es_hit1;
  logic es_hit2;

  assign es_hit1 = hit(i_es_rd, i_rs1);
  assign es_hit2 = hit(i_es_rd, i_rs2);

  // youngest producer wins
  assign o_rs1_data = es_hit1               ? i_es_result :
                      hit(i_ms_rd, i_rs1) ? i_ms_result :
                      hit(i_ws_rd, i_rs1) ? i_ws_result :
                                            i_rf_rs1;

  assign o_rs2_data = es_hit2               ? i_es_result :
                      hit(i_ms_rd, i_rs2) ? i_ms_result :
                      hit(i_ws_rd, i_rs2) ? i_ws_result :
                                            i_rf_rs2;

  assign o_load_stall = i_es_load & (es_hit1 | es_hit2);  // load data not back yet

endmodule

/* verilog/rv_gpr_file.sv */
// 32 x 64-bit integer register file, two asynchronous reads and one write-back port
`timescale 1ns/1ns
`include "rv_id_macros.svh"

module rv_gpr_file (
  input  logic                 i_clk,
  input  logic                 i_arst_n,
  input  rv_id_pkg::reg_addr_t i_raddr1,
  input  rv_id_pkg::reg_addr_t i_raddr2,
  input  logic                 i_wen,
  input  rv_id_pkg::reg_addr_t i_waddr,
  input  rv_id_pkg::xlen_t     i_wdata,
  output rv_id_pkg::xlen_t     o_rdata1,
  output rv_id_pkg::xlen_t     o_rdata2
);
  import rv_id_pkg::*;

  xlen_t regs [1:`RV_NUM_REGS-1];  // no storage for x0

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      for (int i = 1; i < `RV_NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (i_wen && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

endmodule

/* verilog/rv_inst_decode.sv */
// combinational RV64I decoder, turns one instruction word into fields, immediate and controls
`timescale 1ns/1ns
`include "rv_id_macros.svh"

module rv_inst_decode (
  input  rv_id_pkg::inst_t     i_inst,
  output rv_id_pkg::reg_addr_t o_rs1,
  output rv_id_pkg::reg_addr_t o_rs2,
  output rv_id_pkg::reg_addr_t o_rd,
  output rv_id_pkg::xlen_t     o_imm,
  output rv_id_pkg::alu_op_t   o_alu_op,
  output logic                 o_alu_src1_pc,
  output logic                 o_alu_src2_imm,
  output logic                 o_word_sel,
  output logic                 o_gpr_wen,
  output logic                 o_mem_ren,
  output logic                 o_mem_wen,
  output logic                 o_load,
  output logic                 o_bren,
  output logic                 o_jal,
  output logic                 o_jalr,
  output rv_id_pkg::mem_op_t   o_mem_op,
  output logic [2:0]           o_br_func,
  output logic                 o_invalid
);
  import rv_id_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7_b5;  // sub and sra
  logic       reg_form;
  logic       use_rs1;
  logic       use_rs2;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;
  alu_op_t    arith_op;

  assign opcode    = i_inst[6:0];
  assign funct3    = i_inst[14:12];
  assign funct7_b5 = i_inst[30];
  assign reg_form  = (opcode == `RV_OPC_OP) || (opcode == `RV_OPC_OP_32);

  assign imm_i = {{52{i_inst[31]}}, i_inst[31:20]};
  assign imm_s = {{52{i_inst[31]}}, i_inst[31:25], i_inst[11:7]};
  assign imm_b = {{51{i_inst[31]}}, i_inst[31], i_inst[7], i_inst[30:25], i_inst[11:8], 1'b0};
  assign imm_u = {{32{i_inst[31]}}, i_inst[31:12], 12'b0};
  assign imm_j = {{43{i_inst[31]}}, i_inst[31], i_inst[19:12], i_inst[20], i_inst[30:21], 1'b0};

  // shared by OP, OP-IMM and the word forms
  always_comb begin
    case (funct3)
      3'b000:  arith_op = (reg_form && funct7_b5) ? `RV_ALU_SUB : `RV_ALU_ADD;
      3'b001:  arith_op = `RV_ALU_SLL;
      3'b010:  arith_op = `RV_ALU_SLT;
      3'b011:  arith_op = `RV_ALU_SLTU;
      3'b100:  arith_op = `RV_ALU_XOR;
      3'b101:  arith_op = funct7_b5 ? `RV_ALU_SRA : `RV_ALU_SRL;
      3'b110:  arith_op = `RV_ALU_OR;
      default: arith_op = `RV_ALU_AND;
    endcase
  end

  always_comb begin
    o_imm          = imm_i;
    o_alu_op       = `RV_ALU_ADD;
    o_alu_src1_pc  = 1'b0;
    o_alu_src2_imm = 1'b0;
    o_word_sel     = 1'b0;
    o_gpr_wen      = 1'b0;
    o_mem_ren      = 1'b0;
    o_mem_wen      = 1'b0;
    o_load         = 1'b0;
    o_bren         = 1'b0;
    o_jal          = 1'b0;
    o_jalr         = 1'b0;
    o_invalid      = 1'b0;
    use_rs1        = 1'b0;
    use_rs2        = 1'b0;
    case (opcode)
      `RV_OPC_LUI: begin
        o_imm          = imm_u;
        o_alu_op       = `RV_ALU_LUI;
        o_alu_src2_imm = 1'b1;
        o_gpr_wen      = 1'b1;
      end
      `RV_OPC_AUIPC: begin
        o_imm          = imm_u;
        o_alu_src1_pc  = 1'b1;
        o_alu_src2_imm = 1'b1;
        o_gpr_wen      = 1'b1;
      end
      // pc as src1 without imm means the link value pc + 4
      `RV_OPC_JAL: begin
        o_imm         = imm_j;
        o_alu_src1_pc = 1'b1;
        o_gpr_wen     = 1'b1;
        o_jal         = 1'b1;
      end
      `RV_OPC_JALR: begin
        o_alu_src1_pc = 1'b1;
        o_gpr_wen     = 1'b1;
        o_jalr        = 1'b1;
        use_rs1       = 1'b1;
      end
      `RV_OPC_BRANCH: begin
        o_imm   = imm_b;
        o_bren  = 1'b1;
        use_rs1 = 1'b1;
        use_rs2 = 1'b1;
      end
      `RV_OPC_LOAD: begin
        o_alu_src2_imm = 1'b1;
        o_gpr_wen      = 1'b1;
        o_mem_ren      = 1'b1;
        o_load         = 1'b1;
        use_rs1        = 1'b1;
      end
      `RV_OPC_STORE: begin
        o_imm          = imm_s;
        o_alu_src2_imm = 1'b1;
        o_mem_wen      = 1'b1;
        use_rs1        = 1'b1;
        use_rs2        = 1'b1;
      end
      `RV_OPC_OP, `RV_OPC_OP_32: begin
        o_alu_op   = arith_op;
        o_word_sel = (opcode == `RV_OPC_OP_32);
        o_gpr_wen  = 1'b1;
        use_rs1    = 1'b1;
        use_rs2    = 1'b1;
      end
      `RV_OPC_OP_IMM, `RV_OPC_OP_IMM_32: begin
        o_alu_op       = arith_op;
        o_alu_src2_imm = 1'b1;
        o_word_sel     = (opcode == `RV_OPC_OP_IMM_32);
        o_gpr_wen      = 1'b1;
        use_rs1        = 1'b1;
      end
      default: o_invalid = 1'b1;
    endcase
  end

  // unused source fields read as x0 so they never raise a false hazard
  assign o_rs1     = use_rs1 ? i_inst[19:15] : '0;
  assign o_rs2     = use_rs2 ? i_inst[24:20] : '0;
  assign o_rd      = o_gpr_wen ? i_inst[11:7] : '0;
  assign o_mem_op  = funct3;
  assign o_br_func = funct3;

endmodule

/* verilog/rv_id_latch.sv */
// decode stage occupancy and instruction/pc register, handles the fetch-to-execute handshake
`timescale 1ns/1ns

module rv_id_latch (
  input  logic             i_clk,
  input  logic             i_arst_n,
  input  logic             i_fs_to_ds_valid,
  input  rv_id_pkg::inst_t i_fs_inst,
  input  rv_id_pkg::xlen_t i_fs_pc,
  input  logic             i_es_allowin,
  input  logic             i_load_stall,
  output logic             o_ds_allowin,
  output logic             o_ds_valid,
  output logic             o_ds_to_es_valid,
  output rv_id_pkg::inst_t o_inst,
  output rv_id_pkg::xlen_t o_pc
);
  import rv_id_pkg::*;

  logic  ds_ready_go;
  inst_t inst_r;
  xlen_t pc_r;

  assign ds_ready_go      = ~i_load_stall;
  // empty, or the current one leaves this edge
  assign o_ds_allowin     = ~o_ds_valid | (ds_ready_go & i_es_allowin);
  assign o_ds_to_es_valid = o_ds_valid & ds_ready_go;

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_ds_valid <= 1'b0;
    end else if (o_ds_allowin) begin
      o_ds_valid <= i_fs_to_ds_valid;
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_fs_to_ds_valid && o_ds_allowin) begin  // accepting edge
      inst_r <= i_fs_inst;
      pc_r   <= i_fs_pc;
    end
  end

  assign o_inst = inst_r;
  assign o_pc   = pc_r;

endmodule

/* verilog/rv_id_pkg.sv */
// vector types shared by the decode stage modules, imported where a module needs them
`include "rv_id_macros.svh"

package rv_id_pkg;

  // data, pc and immediate values
  typedef logic [`RV_XLEN-1:0]       xlen_t;

  typedef logic [`RV_INST_W-1:0]     inst_t;

  typedef logic [`RV_REG_ADDR_W-1:0] reg_addr_t;

  typedef logic [`RV_ALU_OP_W-1:0]   alu_op_t;

  // load/store size and sign, straight from funct3
  typedef logic [2:0]                mem_op_t;

endpackage

/* verilog/rv_id_macros.svh */
// RV64I decode constants (opcodes, funct3, ALU ops, widths), included by the RTL and the testbench
`ifndef RV_ID_MACROS_SVH
`define RV_ID_MACROS_SVH

`define RV_XLEN        64
`define RV_INST_W      32
`define RV_REG_ADDR_W  5
`define RV_NUM_REGS    32
`define RV_ALU_OP_W    4

`define RV_OPC_LUI       7'b0110111
`define RV_OPC_AUIPC     7'b0010111
`define RV_OPC_JAL       7'b1101111
`define RV_OPC_JALR      7'b1100111
`define RV_OPC_BRANCH    7'b1100011
`define RV_OPC_LOAD      7'b0000011
`define RV_OPC_STORE     7'b0100011
`define RV_OPC_OP        7'b0110011
`define RV_OPC_OP_IMM    7'b0010011
`define RV_OPC_OP_32     7'b0111011
`define RV_OPC_OP_IMM_32 7'b0011011

`define RV_F3_BEQ  3'b000
`define RV_F3_BNE  3'b001
`define RV_F3_BLT  3'b100
`define RV_F3_BGE  3'b101
`define RV_F3_BLTU 3'b110
`define RV_F3_BGEU 3'b111

`define RV_ALU_ADD  4'd0
`define RV_ALU_SUB  4'd1
`define RV_ALU_SLL  4'd2
`define RV_ALU_SLT  4'd3
`define RV_ALU_SLTU 4'd4
`define RV_ALU_XOR  4'd5
`define RV_ALU_SRL  4'd6
`define RV_ALU_SRA  4'd7
`define RV_ALU_OR   4'd8
`define RV_ALU_AND  4'd9
`define RV_ALU_LUI  4'd10  // pass imm through

`endif
